/* soc_config.svh */
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// shared on-chip memory
`define SHARED_BASE 32'hC000_0000
`define SHARED_WORDS 1024

// io register block
`define IO_BASE 32'h2000_0800
`define IO_WORDS 4

// framebuffer window, in word indices of the shared memory
`define SCAN_FIRST 512
`define SCAN_WORDS 16

// interval timer reload width
`define TIMER_W 16

`endif

/* soc_pkg.sv */
package soc_pkg;

  // classic bus request from the CPU side
  typedef struct packed {
    logic        cyc;
    logic        we;
    logic [3:0]  sel;
    logic [31:0] adr;
    logic [31:0] dat;
  } bus_req_t;

  // response back to the CPU
  typedef struct packed {
    logic        ack;
    logic        err;
    logic [31:0] dat;
  } bus_rsp_t;

  // word-addressed request into the shared memory
  typedef struct packed {
    logic        stb;
    logic        we;
    logic [3:0]  sel;
    logic [9:0]  word;
    logic [31:0] dat;
  } mem_req_t;

  typedef enum logic [1:0] {
    REGION_NONE,
    REGION_SHARED,
    REGION_IO
  } region_t;

endpackage

/* bus_fabric.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module bus_fabric (
  input  logic              sysclock,
  input  logic              rst_n,
  input  soc_pkg::bus_req_t cpu_req_i,
  output soc_pkg::bus_rsp_t cpu_rsp_o,
  output soc_pkg::mem_req_t cpu_mem_req_o,
  input  logic              cpu_mem_ack_i,
  input  logic [31:0]       mem_rdata_i,
  output logic              io_cyc_o,
  output logic              io_we_o,
  output logic [3:0]        io_sel_o,
  output logic [1:0]        io_word_o,
  output logic [31:0]       io_wdata_o,
  input  logic              io_ack_i,
  input  logic [31:0]       io_rdata_i
);
  import soc_pkg::*;

  region_t     region;
  logic [31:0] shared_off;
  logic [31:0] io_off;
  logic        unmapped_cyc;
  logic        err_ack_q;
  logic        err_done_q;

  // offsets wrap below the base, so one compare per region is enough
  assign shared_off = cpu_req_i.adr - `SHARED_BASE;
  assign io_off     = cpu_req_i.adr - `IO_BASE;

  always_comb begin
    if (shared_off < 32'(4 * `SHARED_WORDS))
      region = REGION_SHARED;
    else if (io_off < 32'(4 * `IO_WORDS))
      region = REGION_IO;
    else
      region = REGION_NONE;
  end

  assign cpu_mem_req_o.stb  = cpu_req_i.cyc && (region == REGION_SHARED);
  assign cpu_mem_req_o.we   = cpu_req_i.we;
  assign cpu_mem_req_o.sel  = cpu_req_i.sel;
  assign cpu_mem_req_o.word = cpu_req_i.adr[11:2];
  assign cpu_mem_req_o.dat  = cpu_req_i.dat;

  assign io_cyc_o   = cpu_req_i.cyc && (region == REGION_IO);
  assign io_we_o    = cpu_req_i.we;
  assign io_sel_o   = cpu_req_i.sel;
  assign io_word_o  = cpu_req_i.adr[3:2];
  assign io_wdata_o = cpu_req_i.dat;

  // unmapped: one ack with err, then quiet until cyc drops
  assign unmapped_cyc = cpu_req_i.cyc && (region == REGION_NONE);

  always_ff @(posedge sysclock or negedge rst_n) begin
    if (!rst_n) begin
      err_ack_q  <= 1'b0;
      err_done_q <= 1'b0;
    end else begin
      err_ack_q  <= unmapped_cyc && !err_ack_q && !err_done_q;
      err_done_q <= unmapped_cyc && (err_done_q || err_ack_q);
    end
  end

  always_comb begin
    cpu_rsp_o = '0;
    case (region)
      REGION_SHARED: begin
        cpu_rsp_o.ack = cpu_mem_ack_i;
        cpu_rsp_o.dat = mem_rdata_i;
      end
      REGION_IO: begin
        cpu_rsp_o.ack = io_ack_i;
        cpu_rsp_o.dat = io_rdata_i;
      end
      default: begin
        cpu_rsp_o.ack = err_ack_q;
        cpu_rsp_o.err = err_ack_q;
      end
    endcase
  end

endmodule

/* ssram_arbiter.sv */
`timescale 1ns/100ps

module ssram_arbiter (
  input  logic              sysclock,
  input  logic              rst_n,
  input  soc_pkg::mem_req_t cpu_req_i,
  input  soc_pkg::mem_req_t scan_req_i,
  output soc_pkg::mem_req_t mem_req_o,
  input  logic              mem_ack_i,
  output logic              cpu_ack_o,
  output logic              scan_ack_o
);

  typedef enum logic [1:0] {
    IDLE,
    GNT_CPU,
    GNT_SCAN
  } arb_state_t;

  arb_state_t state_q;
  logic       last_cpu_q;
  logic       cpu_gnt;
  logic       scan_gnt;

  always_ff @(posedge sysclock or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= IDLE;
      last_cpu_q <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          // on a tie the side not served last goes first
          if (cpu_req_i.stb && (!scan_req_i.stb || !last_cpu_q)) begin
            state_q    <= GNT_CPU;
            last_cpu_q <= 1'b1;
          end else if (scan_req_i.stb) begin
            state_q    <= GNT_SCAN;
            last_cpu_q <= 1'b0;
          end
        end
        GNT_CPU, GNT_SCAN: begin
          if (mem_ack_i)
            state_q <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign cpu_gnt  = (state_q == GNT_CPU);
  assign scan_gnt = (state_q == GNT_SCAN);

  always_comb begin
    mem_req_o = '0;
    if (cpu_gnt)
      mem_req_o = cpu_req_i;
    else if (scan_gnt)
      mem_req_o = scan_req_i;
  end

  assign cpu_ack_o  = cpu_gnt && mem_ack_i;
  assign scan_ack_o = scan_gnt && mem_ack_i;

endmodule

/* shared_ram.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module shared_ram (
  input  logic              sysclock,
  input  logic              rst_n,
  input  soc_pkg::mem_req_t mem_req_i,
  output logic              mem_ack_o,
  output logic [31:0]       mem_rdata_o
);

  logic [31:0] mem_q [`SHARED_WORDS];
  logic        ack_q;
  logic        accept;

  // strobe stays up during the ack cycle, don't take it twice
  assign accept = mem_req_i.stb && !ack_q;

  always_ff @(posedge sysclock or negedge rst_n) begin
    if (!rst_n)
      ack_q <= 1'b0;
    else
      ack_q <= accept;
  end

  always_ff @(posedge sysclock) begin
    if (accept) begin
      if (mem_req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (mem_req_i.sel[b])
            mem_q[mem_req_i.word][8*b +: 8] <= mem_req_i.dat[8*b +: 8];
        end
      end else begin
        mem_rdata_o <= mem_q[mem_req_i.word];
      end
    end
  end

  assign mem_ack_o = ack_q;

endmodule

/* scan_reader.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module scan_reader (
  input  logic              sysclock,
  input  logic              rst_n,
  input  logic              scan_en_i,
  output soc_pkg::mem_req_t scan_req_o,
  input  logic              scan_ack_i,
  input  logic [31:0]       scan_rdata_i,
  output logic [31:0]       pixel_o,
  output logic              pixel_valid_o
);

  localparam logic [9:0] FIRST_WORD = 10'(`SCAN_FIRST);
  localparam logic [9:0] LAST_WORD  = 10'(`SCAN_FIRST + `SCAN_WORDS - 1);

  logic [9:0] ptr_q;
  logic       busy_q;

  always_ff @(posedge sysclock or negedge rst_n) begin
    if (!rst_n) begin
      ptr_q         <= FIRST_WORD;
      busy_q        <= 1'b0;
      pixel_valid_o <= 1'b0;
    end else begin
      pixel_valid_o <= 1'b0;
      if (busy_q) begin
        if (scan_ack_i) begin
          pixel_valid_o <= 1'b1;
          ptr_q         <= (ptr_q == LAST_WORD) ? FIRST_WORD : ptr_q + 10'd1;
          // next read right away unless the display was switched off
          busy_q        <= scan_en_i;
        end
      end else if (scan_en_i) begin
        busy_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge sysclock) begin
    if (busy_q && scan_ack_i)
      pixel_o <= scan_rdata_i;
  end

  assign scan_req_o.stb  = busy_q;
  assign scan_req_o.we   = 1'b0;
  assign scan_req_o.sel  = 4'hf;
  assign scan_req_o.word = ptr_q;
  assign scan_req_o.dat  = '0;

endmodule

/* io_regs.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module io_regs (
  input  logic                sysclock,
  input  logic                rst_n,
  input  logic                cyc_i,
  input  logic                we_i,
  input  logic [3:0]          sel_i,
  input  logic [1:0]          word_i,
  input  logic [31:0]         wdata_i,
  output logic                ack_o,
  output logic [31:0]         rdata_o,
  input  logic                tick_i,
  output logic                timer_en_o,
  output logic [`TIMER_W-1:0] timer_reload_o,
  output logic                scan_en_o,
  output logic [15:0]         led_o,
  output logic                irq_o
);

  logic [15:0]         led_q;
  logic [`TIMER_W-1:0] reload_q;
  logic [1:0]          ctrl_q;
  logic                status_q;
  logic                ack_q;
  logic                access;
  logic                wr;

  assign access = cyc_i && !ack_q;
  assign wr     = access && we_i;

  always_ff @(posedge sysclock or negedge rst_n) begin
    if (!rst_n) begin
      ack_q    <= 1'b0;
      led_q    <= '0;
      reload_q <= '0;
      ctrl_q   <= '0;
      status_q <= 1'b0;
    end else begin
      ack_q <= access;
      if (wr && word_i == 2'd0) begin
        if (sel_i[0]) led_q[7:0]  <= wdata_i[7:0];
        if (sel_i[1]) led_q[15:8] <= wdata_i[15:8];
      end
      if (wr && word_i == 2'd1) begin
        if (sel_i[0]) reload_q[7:0]          <= wdata_i[7:0];
        if (sel_i[1]) reload_q[`TIMER_W-1:8] <= wdata_i[`TIMER_W-1:8];
      end
      if (wr && word_i == 2'd2 && sel_i[0])
        ctrl_q <= wdata_i[1:0];
      // a tick in the same cycle beats the clear
      if (tick_i)
        status_q <= 1'b1;
      else if (wr && word_i == 2'd3 && sel_i[0] && wdata_i[0])
        status_q <= 1'b0;
    end
  end

  always_ff @(posedge sysclock) begin
    if (access) begin
      case (word_i)
        2'd0:    rdata_o <= {16'h0, led_q};
        2'd1:    rdata_o <= {{(32-`TIMER_W){1'b0}}, reload_q};
        2'd2:    rdata_o <= {30'h0, ctrl_q};
        default: rdata_o <= {31'h0, status_q};
      endcase
    end
  end

  assign ack_o          = ack_q;
  assign led_o          = led_q;
  assign timer_reload_o = reload_q;
  assign timer_en_o     = ctrl_q[0];
  assign scan_en_o      = ctrl_q[1];
  assign irq_o          = status_q;

endmodule

/* interval_timer.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module interval_timer (
  input  logic                sysclock,
  input  logic                rst_n,
  input  logic                enable_i,
  input  logic [`TIMER_W-1:0] reload_i,
  output logic                tick_o
);

  logic [`TIMER_W-1:0] count_q;
  logic                en_q;

  always_ff @(posedge sysclock or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
      en_q    <= 1'b0;
    end else begin
      en_q <= enable_i;
      if (enable_i && !en_q)
        count_q <= reload_i;
      else if (enable_i) begin
        if (count_q == '0)
          count_q <= reload_i;
        else
          count_q <= count_q - 1'b1;
      end
    end
  end

  // period is reload + 1 cycles
  assign tick_o = enable_i && en_q && (count_q == '0);

endmodule

/* soc_core.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module soc_core (
  input  logic              sysclock,
  input  logic              rst_n,
  input  soc_pkg::bus_req_t cpu_req_i,
  output soc_pkg::bus_rsp_t cpu_rsp_o,
  output logic [15:0]       led_o,
  output logic              irq_o,
  output logic [31:0]       pixel_o,
  output logic              pixel_valid_o
);
  import soc_pkg::*;

  mem_req_t            cpu_mem_req;
  mem_req_t            scan_mem_req;
  mem_req_t            ram_req;
  logic                cpu_mem_ack;
  logic                scan_mem_ack;
  logic                ram_ack;
  logic [31:0]         mem_rdata;
  logic                io_cyc;
  logic                io_we;
  logic [3:0]          io_sel;
  logic [1:0]          io_word;
  logic [31:0]         io_wdata;
  logic                io_ack;
  logic [31:0]         io_rdata;
  logic                timer_en;
  logic [`TIMER_W-1:0] timer_reload;
  logic                tick;
  logic                scan_en;

  bus_fabric bus_fabric_i (
    .sysclock(sysclock), .rst_n(rst_n),
    .cpu_req_i(cpu_req_i), .cpu_rsp_o(cpu_rsp_o),
    .cpu_mem_req_o(cpu_mem_req), .cpu_mem_ack_i(cpu_mem_ack), .mem_rdata_i(mem_rdata),
    .io_cyc_o(io_cyc), .io_we_o(io_we), .io_sel_o(io_sel), .io_word_o(io_word),
    .io_wdata_o(io_wdata), .io_ack_i(io_ack), .io_rdata_i(io_rdata));

  ssram_arbiter ssram_arbiter_i (
    .sysclock(sysclock), .rst_n(rst_n),
    .cpu_req_i(cpu_mem_req), .scan_req_i(scan_mem_req), .mem_req_o(ram_req),
    .mem_ack_i(ram_ack), .cpu_ack_o(cpu_mem_ack), .scan_ack_o(scan_mem_ack));

  shared_ram shared_ram_i (
    .sysclock(sysclock), .rst_n(rst_n),
    .mem_req_i(ram_req), .mem_ack_o(ram_ack), .mem_rdata_o(mem_rdata));

  // display master, second owner of the shared memory
  scan_reader scan_reader_i (
    .sysclock(sysclock), .rst_n(rst_n), .scan_en_i(scan_en),
    .scan_req_o(scan_mem_req), .scan_ack_i(scan_mem_ack), .scan_rdata_i(mem_rdata),
    .pixel_o(pixel_o), .pixel_valid_o(pixel_valid_o));

  io_regs io_regs_i (
    .sysclock(sysclock), .rst_n(rst_n),
    .cyc_i(io_cyc), .we_i(io_we), .sel_i(io_sel), .word_i(io_word), .wdata_i(io_wdata),
    .ack_o(io_ack), .rdata_o(io_rdata), .tick_i(tick),
    .timer_en_o(timer_en), .timer_reload_o(timer_reload), .scan_en_o(scan_en),
    .led_o(led_o), .irq_o(irq_o));

  interval_timer interval_timer_i (
    .sysclock(sysclock), .rst_n(rst_n),
    .enable_i(timer_en), .reload_i(timer_reload), .tick_o(tick));

endmodule

/* soc_assertions.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module soc_assertions (
  input logic        sysclock,
  input logic        rst_n,
  input logic        ack_i,
  input logic        err_i,
  input logic [31:0] adr_i,
  input logic        cpu_stb_i,
  input logic        scan_stb_i,
  input logic        cpu_gnt_i,
  input logic        scan_gnt_i,
  input logic        scan_ack_i,
  input logic        pixel_valid_i
);

  localparam logic [31:0] SHARED_END = `SHARED_BASE + 32'(4 * `SHARED_WORDS);
  localparam logic [31:0] IO_END     = `IO_BASE + 32'(4 * `IO_WORDS);

  logic mapped;

  // address lies in the shared memory or the io block
  assign mapped = (adr_i >= `SHARED_BASE && adr_i < SHARED_END) ||
                  (adr_i >= `IO_BASE && adr_i < IO_END);

  ack_single_cycle: assert property (@(posedge sysclock) disable iff (!rst_n)
    ack_i |=> !ack_i)
    else $error("cpu ack stayed high for two cycles");

  err_with_ack: assert property (@(posedge sysclock) disable iff (!rst_n)
    err_i |-> ack_i && !mapped)
    else $error("cpu err seen without ack or for a mapped address");

  // only one owner of the shared memory, and it is asking for it
  one_grant: assert property (@(posedge sysclock) disable iff (!rst_n)
    !(cpu_gnt_i && scan_gnt_i) && (!cpu_gnt_i || cpu_stb_i) && (!scan_gnt_i || scan_stb_i))
    else $error("arbiter granted both masters or a master that was not requesting");

  pixel_after_ack: assert property (@(posedge sysclock) disable iff (!rst_n)
    pixel_valid_i |-> $past(scan_ack_i))
    else $error("pixel strobe without a scan ack before it");

endmodule

bind soc_core soc_assertions soc_assertions_i (
  .sysclock(sysclock),
  .rst_n(rst_n),
  .ack_i(cpu_rsp_o.ack),
  .err_i(cpu_rsp_o.err),
  .adr_i(cpu_req_i.adr),
  .cpu_stb_i(cpu_mem_req.stb),
  .scan_stb_i(scan_mem_req.stb),
  .cpu_gnt_i(ssram_arbiter_i.cpu_gnt),
  .scan_gnt_i(ssram_arbiter_i.scan_gnt),
  .scan_ack_i(scan_mem_ack),
  .pixel_valid_i(pixel_valid_o)
);

/* tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 8
) (
  output logic sysclock_o,
  output logic rst_n_o
);

  initial begin
    sysclock_o = 1'b0;
    forever #(PERIOD_NS / 2) sysclock_o = ~sysclock_o;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge sysclock_o);
    @(negedge sysclock_o);
    rst_n_o = 1'b1;
  end

endmodule

/* tb_soc.sv */
`timescale 1ns/100ps
`include "soc_config.svh"

module tb_soc;
  import soc_pkg::*;

  localparam int N_INIT     = 64;
  localparam int N_RANDOM   = 200;
  localparam int N_IO       = 40;
  localparam int N_UNMAPPED = 10;
  localparam int N_SCAN_CPU = 100;
  localparam int R_MAX      = 23;
  localparam int PIX_TARGET = 2 * `SCAN_WORDS + 8;
  localparam int ACK_LIMIT  = 32;
  // every transfer of every test, about 8 cycles each under contention
  localparam int N_XFER = 2 * N_INIT + N_RANDOM + 2 * N_IO + 4 * N_UNMAPPED
                          + `SCAN_WORDS + N_SCAN_CPU + 16;
  localparam int TIMEOUT_CYCLES = 8 * N_XFER + 4 * (R_MAX + 4) + 8 * PIX_TARGET + 200;

  logic        sysclock;
  logic        rst_n;
  bus_req_t    cpu_req;
  bus_rsp_t    cpu_rsp;
  logic [15:0] led;
  logic        irq;
  logic [31:0] pixel;
  logic        pixel_valid;

  integer      seed;
  int          checks;
  int          errors;
  int          checks_mark;
  int          errors_mark;

  // reference model
  logic [31:0] mem_model [`SHARED_WORDS];
  logic [15:0] led_m;
  logic [15:0] reload_m;
  logic [1:0]  ctrl_m;

  // monitor state
  int          cycle;
  logic        irq_q;
  int          irq_rises;
  int          rise_last;
  int          rise_prev;
  int          pix_idx;
  int          pix_count;

  tb_clock_gen tb_clock_gen_i (.sysclock_o(sysclock), .rst_n_o(rst_n));

  soc_core soc_core_i (
    .sysclock(sysclock), .rst_n(rst_n),
    .cpu_req_i(cpu_req), .cpu_rsp_o(cpu_rsp),
    .led_o(led), .irq_o(irq), .pixel_o(pixel), .pixel_valid_o(pixel_valid));

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdat,
                                              input logic [3:0] sel);
    logic [31:0] mask;
    mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
    return (old & ~mask) | (wdat & mask);
  endfunction

  function automatic logic [31:0] io_expect(input int word);
    case (word)
      0:       return {16'h0, led_m};
      1:       return {16'h0, reload_m};
      2:       return {30'h0, ctrl_m};
      default: return 32'h0;
    endcase
  endfunction

  function automatic bit in_map(input logic [31:0] adr);
    return (adr >= `SHARED_BASE && adr < `SHARED_BASE + 32'(4 * `SHARED_WORDS)) ||
           (adr >= `IO_BASE && adr < `IO_BASE + 32'h10);
  endfunction

  task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic ensure(input bit cond, input string msg);
    checks++;
    assert (cond) else begin
      errors++;
      $display("%s", msg);
    end
  endtask

  task automatic report_test(input string name);
    $display("%s: %0d checks, %0d errors", name, checks - checks_mark, errors - errors_mark);
    checks_mark = checks;
    errors_mark = errors;
  endtask

  // one classic bus cycle: raise cyc, wait for ack, drop cyc
  task automatic bus_xfer(input bit we, input logic [3:0] sel, input logic [31:0] adr,
                          input logic [31:0] wdat, output bus_rsp_t rsp, output int lat);
    bus_req_t req;
    int       waited;
    bit       got_ack;
    req.cyc = 1'b1;
    req.we  = we;
    req.sel = sel;
    req.adr = adr;
    req.dat = wdat;
    rsp     = '0;
    waited  = 0;
    got_ack = 1'b0;
    @(posedge sysclock);
    cpu_req <= req;
    while (!got_ack && waited < ACK_LIMIT) begin
      @(posedge sysclock);
      waited++;
      if (cpu_rsp.ack) begin
        got_ack = 1'b1;
        rsp     = cpu_rsp;
      end
    end
    cpu_req.cyc <= 1'b0;
    lat = waited - 1;
    ensure(got_ack, $sformatf("no ack for the access to %h within %0d cycles", adr, ACK_LIMIT));
  endtask

  task automatic mem_access(input bit we, input int idx, input logic [3:0] sel,
                            input logic [31:0] dat, input bit idle);
    bus_rsp_t rsp;
    int       lat;
    bus_xfer(we, sel, `SHARED_BASE + 32'(4 * idx), dat, rsp, lat);
    compare_word("cpu_rsp_o.err", {31'h0, rsp.err}, 32'h0);
    // grant plus registered read
    if (idle)
      compare_word("shared ack latency", lat, 2);
    if (we)
      mem_model[idx] = merge_bytes(mem_model[idx], dat, sel);
    else
      compare_word($sformatf("cpu_rsp_o.dat word %0d", idx), rsp.dat, mem_model[idx]);
  endtask

  task automatic io_access(input bit we, input int word, input logic [3:0] sel,
                           input logic [31:0] dat);
    bus_rsp_t    rsp;
    int          lat;
    logic [31:0] merged;
    bus_xfer(we, sel, `IO_BASE + 32'(4 * word), dat, rsp, lat);
    compare_word("cpu_rsp_o.err", {31'h0, rsp.err}, 32'h0);
    compare_word("io ack latency", lat, 1);
    if (we) begin
      merged = merge_bytes({16'h0, (word == 0) ? led_m : reload_m}, dat, sel);
      if (word == 0)
        led_m = merged[15:0];
      if (word == 1)
        reload_m = merged[15:0];
      if (word == 2 && sel[0])
        ctrl_m = dat[1:0];
    end else begin
      compare_word($sformatf("cpu_rsp_o.dat io word %0d", word), rsp.dat, io_expect(word));
    end
  endtask

  task automatic verify_error_rsp(input bus_rsp_t rsp, input int lat);
    compare_word("cpu_rsp_o.err", {31'h0, rsp.err}, 32'h1);
    compare_word("cpu_rsp_o.dat", rsp.dat, 32'h0);
    compare_word("error ack latency", lat, 1);
  endtask

  task automatic random_traffic(input int count, input bit idle);
    int          idx;
    bit          we;
    logic [3:0]  sel;
    logic [31:0] dat;
    for (int i = 0; i < count; i++) begin
      idx = $unsigned($random(seed)) % N_INIT;
      we  = 1'($random(seed));
      sel = 4'($random(seed));
      dat = $random(seed);
      mem_access(we, idx, we ? sel : 4'hf, dat, idle);
    end
  endtask

  // cycle count, irq rise times and pixel order
  always @(posedge sysclock or negedge rst_n) begin
    if (!rst_n) begin
      cycle     <= 0;
      irq_q     <= 1'b0;
      irq_rises <= 0;
      rise_last <= 0;
      rise_prev <= 0;
      pix_idx   <= 0;
      pix_count <= 0;
    end else begin
      cycle <= cycle + 1;
      irq_q <= irq;
      if (irq && !irq_q) begin
        rise_prev <= rise_last;
        rise_last <= cycle;
        irq_rises <= irq_rises + 1;
      end
      if (pixel_valid) begin
        compare_word("pixel_o", pixel, mem_model[`SCAN_FIRST + pix_idx]);
        pix_idx   <= (pix_idx == `SCAN_WORDS - 1) ? 0 : pix_idx + 1;
        pix_count <= pix_count + 1;
      end
    end
  end

  initial begin
    wait (rst_n === 1'b1);
    while (cycle < TIMEOUT_CYCLES)
      @(posedge sysclock);
    $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    bus_rsp_t    rsp;
    logic [31:0] adr;
    logic [31:0] dat;
    int          lat;
    int          idx;
    int          word;
    int          reload;
    int          waited;
    cpu_req     <= '0;
    seed        = 21;
    checks      = 0;
    errors      = 0;
    checks_mark = 0;
    errors_mark = 0;
    led_m       = '0;
    reload_m    = '0;
    ctrl_m      = '0;
    wait (rst_n === 1'b1);

    for (int i = 0; i < N_INIT; i++) begin
      dat = $random(seed);
      mem_access(1'b1, i, 4'hf, dat, 1'b1);
    end
    random_traffic(N_RANDOM, 1'b1);
    for (int i = 0; i < N_INIT; i++)
      mem_access(1'b0, i, 4'hf, 32'h0, 1'b1);
    report_test("shared memory");

    for (int i = 0; i < N_IO; i++) begin
      word = $unsigned($random(seed)) % 3;
      dat  = $random(seed);
      // keep timer and scan off here
      if (word == 2)
        dat[1:0] = 2'b00;
      io_access(1'b1, word, 4'($random(seed)), dat);
      compare_word("led_o", {16'h0, led}, {16'h0, led_m});
      io_access(1'b0, word, 4'hf, 32'h0);
    end
    io_access(1'b0, 3, 4'hf, 32'h0);
    report_test("io registers");

    for (int i = 0; i < N_UNMAPPED; i++) begin
      if (i == 0)
        adr = `SHARED_BASE + 32'(4 * `SHARED_WORDS);
      else if (i == 1)
        adr = `IO_BASE + 32'h10;
      else begin
        adr = $random(seed) & 32'hffff_f0fc;
        while (in_map(adr))
          adr = $random(seed) & 32'hffff_f0fc;
      end
      dat = $random(seed);
      bus_xfer(1'b1, 4'hf, adr, dat, rsp, lat);
      verify_error_rsp(rsp, lat);
      bus_xfer(1'b0, 4'hf, adr, 32'h0, rsp, lat);
      verify_error_rsp(rsp, lat);
      // the words the address would alias to stay untouched
      idx = adr[11:2];
      if (idx < N_INIT)
        mem_access(1'b0, idx, 4'hf, 32'h0, 1'b1);
      io_access(1'b0, adr[3:2], 4'hf, 32'h0);
    end
    report_test("unmapped access");

    reload = 8 + $unsigned($random(seed)) % (R_MAX - 7);
    io_access(1'b1, 1, 4'h3, 32'(reload));
    io_access(1'b1, 2, 4'h1, 32'h1);
    waited = 0;
    while (!irq && waited < reload + 3) begin
      @(posedge sysclock);
      waited++;
    end
    ensure(irq, $sformatf("irq_o did not rise within %0d cycles of the timer enable",
                          reload + 3));
    io_access(1'b1, 3, 4'h1, 32'h1);
    io_access(1'b0, 3, 4'hf, 32'h0);
    compare_word("irq_o", {31'h0, irq}, 32'h0);
    waited = 0;
    while (irq_rises < 2 && waited < 2 * reload + 8) begin
      @(posedge sysclock);
      waited++;
    end
    ensure(irq_rises >= 2, "the second timer interrupt never arrived");
    compare_word("timer tick interval", rise_last - rise_prev, reload + 1);
    io_access(1'b1, 2, 4'h1, 32'h0);
    io_access(1'b1, 3, 4'h1, 32'h1);
    report_test("interval timer");

    for (int i = 0; i < `SCAN_WORDS; i++) begin
      dat = $random(seed);
      mem_access(1'b1, `SCAN_FIRST + i, 4'hf, dat, 1'b1);
    end
    io_access(1'b1, 2, 4'h1, 32'h2);
    random_traffic(N_SCAN_CPU, 1'b0);
    waited = 0;
    while (pix_count < PIX_TARGET && waited < 8 * PIX_TARGET) begin
      @(posedge sysclock);
      waited++;
    end
    ensure(pix_count >= PIX_TARGET,
           $sformatf("only %0d pixels came from the scan reader", pix_count));
    io_access(1'b1, 2, 4'h1, 32'h0);
    report_test("scan with cpu traffic");

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+.
soc_pkg.sv
bus_fabric.sv
ssram_arbiter.sv
shared_ram.sv
scan_reader.sv
io_regs.sv
interval_timer.sv
soc_core.sv
soc_assertions.sv
tb_clock_gen.sv
tb_soc.sv

/* run_sim.sh */
#!/bin/sh
# build tb_soc with Verilator, run it, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_soc \
    -f verilog.f -o tb_soc \
  && ./obj_dir/tb_soc | tee sim.log \
  && grep -q '^\*\*\* PASSED \*\*\*$' sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
